/* filelist.f */
+incdir+hw
hw/isaPkg.sv
hw/busPkg.sv
hw/memoryBank.sv
hw/coreFsm.sv
hw/ioBridge.sv
hw/bootSequencer.sv
hw/socTop.sv
tb/socTb.sv

/* hw/bootSequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "system_consts.svh"

module bootSequencer import isaPkg::*, busPkg::*; (
    input  wire logic     Clock,
    input  wire logic     rstN,
    input  wire loadPortT loadPort,
    input  wire logic     loadDone,
    input  wire memReqT   coreFetchReq,
    output memReqT        imemReq,
    output instrT         imemWrite,
    output logic          run
);

    localparam int HoldBits = $clog2(`BOOT_HOLD_CYCLES + 1);

    logic                loadClosed;
    logic [HoldBits-1:0] holdCount;

    // Run is seen one cycle before the core issues its first fetch.
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            loadClosed <= 1'b0;
            holdCount  <= '0;
            run        <= 1'b0;
        end else if (loadDone && !loadClosed) begin
            loadClosed <= 1'b1;
            holdCount  <= HoldBits'(`BOOT_HOLD_CYCLES - 1);
        end else if (holdCount != '0) begin
            holdCount <= holdCount - 1'b1;
            if (holdCount == HoldBits'(1)) begin
                run <= 1'b1;
            end
        end
    end

    always_comb begin
        if (run) begin
            imemReq = coreFetchReq;
        end else begin
            imemReq.rdStb  = 1'b0;
            imemReq.wrStb  = loadPort.wrStb & ~loadClosed; // Port closes at loadDone.
            imemReq.addr   = `WORD_BITS'(loadPort.addr);
            imemReq.wrData = wordT'(loadPort.data);
        end
    end

    assign imemWrite = loadPort.data;

endmodule

`default_nettype wire

/* hw/busPkg.sv */
`default_nettype none
`include "system_consts.svh"

package busPkg;

    import isaPkg::*;

    typedef logic [`WORD_BITS-1:0] wordT;

    typedef logic [7:0] ledT;

    typedef struct packed {
        logic rdStb;
        logic wrStb;
        wordT addr;
        wordT wrData;
    } memReqT;

    typedef struct packed {
        logic done; // One cycle after the request strobe.
        wordT rdData;
    } memRspT;

    typedef struct packed {
        logic                           wrStb;
        logic [$clog2(`IMEM_DEPTH)-1:0] addr;
        instrT                          data;
    } loadPortT;

endpackage

`default_nettype wire

/* hw/coreFsm.sv */
`timescale 1ns/100ps
`default_nettype none
`include "system_consts.svh"

module coreFsm import isaPkg::*, busPkg::*; (
    input  wire logic   Clock,
    input  wire logic   rstN,
    input  wire logic   run,
    input  wire instrT  fetchData,
    input  wire logic   fetchDone,
    input  wire memRspT dataRsp,
    output memReqT      fetchReq,
    output memReqT      dataReq,
    output logic        halted
);

    localparam int PcBits = $clog2(`IMEM_DEPTH);

    typedef enum logic [2:0] {
        sIdle,
        sFetch,
        sWaitFetch,
        sExecute,
        sWaitData,
        sHalt
    } stateT;

    stateT             stateQ;
    logic [PcBits-1:0] pc;
    wordT              regs [4];
    instrT             instr;
    wordT              opA;
    wordT              opB;
    wordT              immZext;

    assign opA     = regs[instr.ra];
    assign opB     = regs[instr.rb];
    assign immZext = `WORD_BITS'(instr.imm);

    always_comb begin
        fetchReq       = '0;
        fetchReq.rdStb = (stateQ == sFetch);
        fetchReq.addr  = `WORD_BITS'(pc); // The pc width makes fetches wrap.
    end

    always_ff @(posedge Clock) begin
        if (stateQ == sWaitFetch && fetchDone) begin
            instr <= fetchData;
        end
    end

    ////////////////////
    // Sequencer

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            stateQ  <= sIdle;
            pc      <= '0;
            regs    <= '{default: '0};
            dataReq <= '0;
            halted  <= 1'b0;
        end else begin
            dataReq.rdStb <= 1'b0;
            dataReq.wrStb <= 1'b0;
            case (stateQ)
                sIdle: begin
                    if (run) begin
                        stateQ <= sFetch;
                    end
                end
                sFetch: begin
                    stateQ <= sWaitFetch;
                end
                sWaitFetch: begin
                    if (fetchDone) begin
                        stateQ <= sExecute;
                    end
                end
                sExecute: begin
                    pc     <= pc + 1'b1;
                    stateQ <= sFetch;
                    case (instr.opcode)
                        opLoadi: regs[instr.rd] <= immZext;
                        opLui:   regs[instr.rd] <= {instr.imm, 16'b0};
                        opAdd:   regs[instr.rd] <= opA + opB;
                        opSub:   regs[instr.rd] <= opA - opB;
                        opLoad, opStore: begin
                            dataReq.rdStb  <= (instr.opcode == opLoad);
                            dataReq.wrStb  <= (instr.opcode == opStore);
                            dataReq.addr   <= opA + immZext;
                            dataReq.wrData <= opB;
                            stateQ         <= sWaitData; // Request goes out next cycle.
                        end
                        opBeqz: begin
                            if (opA == '0) begin
                                pc <= instr.imm[PcBits-1:0];
                            end
                        end
                        opHalt: begin
                            pc     <= pc;
                            halted <= 1'b1;
                            stateQ <= sHalt;
                        end
                        default: ; // Unused codes just step the pc.
                    endcase
                end
                sWaitData: begin
                    if (dataRsp.done) begin
                        if (instr.opcode == opLoad) begin
                            regs[instr.rd] <= dataRsp.rdData;
                        end
                        stateQ <= sFetch;
                    end
                end
                sHalt: begin
                    stateQ <= sHalt; // Only reset leaves this state.
                end
                default: begin
                    stateQ <= sIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/ioBridge.sv */
`timescale 1ns/100ps
`default_nettype none
`include "system_consts.svh"

module ioBridge import busPkg::*; (
    input  wire logic   Clock,
    input  wire logic   rstN,
    input  wire memReqT coreReq,
    input  wire memRspT ramRsp,
    output memReqT      ramReq,
    output memRspT      coreRsp,
    output ledT         led
);

    logic ioSel;
    logic ioSelQ;
    logic ioDone;
    wordT ioRdData;

    assign ioSel = coreReq.addr[`IO_SELECT_BIT];

    always_comb begin
        ramReq       = coreReq;
        ramReq.rdStb = coreReq.rdStb & ~ioSel; // RAM sees only its own half.
        ramReq.wrStb = coreReq.wrStb & ~ioSel;
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            led    <= '0;
            ioSelQ <= 1'b0;
            ioDone <= 1'b0;
        end else begin
            ioDone <= ioSel & (coreReq.rdStb | coreReq.wrStb);
            if (coreReq.rdStb | coreReq.wrStb) begin
                ioSelQ <= ioSel; // Picks the responder in the done cycle.
            end
            if (ioSel & coreReq.wrStb) begin
                led <= coreReq.wrData[$bits(ledT)-1:0];
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (ioSel & coreReq.rdStb) begin
            ioRdData <= `WORD_BITS'(led);
        end
    end

    always_comb begin
        coreRsp.done   = ioSelQ ? ioDone : ramRsp.done;
        coreRsp.rdData = ioSelQ ? ioRdData : ramRsp.rdData;
    end

endmodule

`default_nettype wire

/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

    typedef enum logic [3:0] {
        opLoadi = 4'h0, // rd = imm, zero-extended.
        opLui   = 4'h1, // rd = imm in the upper half.
        opAdd   = 4'h2, // rd = ra + rb.
        opSub   = 4'h3, // rd = ra - rb.
        opLoad  = 4'h4, // rd = mem[ra + imm].
        opStore = 4'h5, // mem[ra + imm] = rb.
        opBeqz  = 4'h6, // pc = imm when ra is zero.
        opHalt  = 4'h7
    } opcodeT;

    typedef logic [1:0] regIdxT;

    // One 32-bit instruction word, opcode in the top nibble.
    typedef struct packed {
        opcodeT      opcode;
        regIdxT      rd;
        regIdxT      ra;
        regIdxT      rb;
        logic [5:0]  spare;
        logic [15:0] imm;
    } instrT;

endpackage

`default_nettype wire

/* hw/memoryBank.sv */
`timescale 1ns/100ps
`default_nettype none
`include "system_consts.svh"

module memoryBank import busPkg::*; #(
    parameter type payloadT = wordT,
    parameter int  Depth    = `DMEM_DEPTH
) (
    input  wire logic    Clock,
    input  wire memReqT  req,
    input  wire payloadT writePayload,
    output payloadT      readPayload,
    output logic         done
);

    localparam int AddrBits = $clog2(Depth);

    payloadT mem [Depth];
    logic [AddrBits-1:0] index;

    assign index = req.addr[AddrBits-1:0]; // Upper address bits are ignored.

    always_ff @(posedge Clock) begin
        if (req.wrStb) begin
            mem[index] <= writePayload;
        end
        if (req.rdStb) begin
            readPayload <= mem[index];
        end
        done <= req.rdStb | req.wrStb; // Every access finishes next cycle.
    end

endmodule

`default_nettype wire

/* hw/socTop.sv */
`timescale 1ns/100ps
`default_nettype none
`include "system_consts.svh"

module socTop import isaPkg::*, busPkg::*; (
    input  wire logic     Clock,
    input  wire logic     rstN,
    input  wire loadPortT loadPort,
    input  wire logic     loadDone,
    output ledT           led,
    output logic          halted
);

    logic   run;
    memReqT fetchReq;
    memReqT imemReq;
    instrT  imemWrite;
    instrT  fetchData;
    logic   fetchDone;
    memReqT dataReq;
    memRspT dataRsp;
    memReqT ramReq;
    memRspT ramRsp;
    wordT   ramRdData;
    logic   ramDone;

    assign ramRsp = '{done: ramDone, rdData: ramRdData};

    ////////////////////
    // Program side

    bootSequencer boot (
        .Clock       (Clock),
        .rstN        (rstN),
        .loadPort    (loadPort),
        .loadDone    (loadDone),
        .coreFetchReq(fetchReq),
        .imemReq     (imemReq),
        .imemWrite   (imemWrite),
        .run         (run)
    );

    memoryBank #(.payloadT(instrT), .Depth(`IMEM_DEPTH)) instMem (
        .Clock       (Clock),
        .req         (imemReq),
        .writePayload(imemWrite),
        .readPayload (fetchData),
        .done        (fetchDone)
    );

    coreFsm core (
        .Clock    (Clock),
        .rstN     (rstN),
        .run      (run),
        .fetchData(fetchData),
        .fetchDone(fetchDone),
        .dataRsp  (dataRsp),
        .fetchReq (fetchReq),
        .dataReq  (dataReq),
        .halted   (halted)
    );

    ////////////////////
    // Data side

    ioBridge bridge (
        .Clock  (Clock),
        .rstN   (rstN),
        .coreReq(dataReq),
        .ramRsp (ramRsp),
        .ramReq (ramReq),
        .coreRsp(dataRsp),
        .led    (led)
    );

    memoryBank #(.payloadT(wordT), .Depth(`DMEM_DEPTH)) dataMem (
        .Clock       (Clock),
        .req         (ramReq),
        .writePayload(ramReq.wrData),
        .readPayload (ramRdData),
        .done        (ramDone)
    );

endmodule

`default_nettype wire

/* hw/system_consts.svh */
`ifndef SYSTEM_CONSTS_SVH
`define SYSTEM_CONSTS_SVH

////////////////////
// Datapath

`define WORD_BITS 32

////////////////////
// Memories

`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

////////////////////
// Address map and start-up

`define IO_SELECT_BIT 31 // Set in a data address means I/O space.
`define BOOT_HOLD_CYCLES 10 // Idle cycles between the end of loading and the first fetch.

`endif

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module socTb -Mdir obj_dir -f filelist.f

./obj_dir/VsocTb | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

/* tb/socTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "system_consts.svh"

module socTb import isaPkg::*, busPkg::*; ();

    localparam int ResetCycles  = 16;
    localparam int StepLimit    = 1000; // Reference runs longer than this never halt.
    localparam int MarginCycles = 40;
    localparam int DmemBits     = $clog2(`DMEM_DEPTH);

    logic     Clock;
    logic     rstN;
    loadPortT loadPort;
    logic     loadDone;
    ledT      led;
    logic     halted;

    instrT prog [`IMEM_DEPTH];
    int    progLen;
    ledT   expLeds [$]; // Expected LED changes, oldest first.
    ledT   expFinalLed;
    int    stepCount;
    int    seed = 13;
    string testName;
    logic  monitorOn = 1'b0;
    ledT   lastLed;
    ledT   nextLed;
    int    cycleCount = 0;
    int    cycleLimit = MarginCycles;

    socTop i_dut (
        .Clock   (Clock),
        .rstN    (rstN),
        .loadPort(loadPort),
        .loadDone(loadDone),
        .led     (led),
        .halted  (halted)
    );

    initial begin
        Clock = 1'b0;
        forever #4 Clock = ~Clock;
    end

    ////////////////////
    // Checks

    task automatic abortRun();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic checkLed(string name, ledT expected, ledT actual);
        if (actual !== expected) begin
            $display("Fail %s: led expected %02h, actual %02h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkHalted(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("Fail %s: halted expected %b, actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run passed its limit of %0d cycles.", cycleLimit);
            abortRun();
        end
    end

    // Every LED change must be the next value from the reference list.
    always @(negedge Clock) begin
        if (monitorOn && led !== lastLed) begin
            if (expLeds.size() == 0) begin
                $display("Test %s: the LED changed to %02h when no change was due.",
                         testName, led);
                abortRun();
            end else begin
                nextLed = expLeds.pop_front();
                checkLed(testName, nextLed, led);
            end
        end
        lastLed <= led;
    end

    ////////////////////
    // Reference model

    function automatic instrT encode(opcodeT op, regIdxT rd, regIdxT ra, regIdxT rb,
                                     logic [15:0] imm);
        instrT word;
        word = '{opcode: op, rd: rd, ra: ra, rb: rb, spare: 6'b0, imm: imm};
        return word;
    endfunction

    // Runs prog as the ISA defines it and returns whether HALT was reached.
    function automatic logic interpret();
        wordT  regs [4];
        wordT  ram [`DMEM_DEPTH];
        wordT  addr;
        instrT ins;
        int    pc;
        ledT   ledVal;
        logic  stopped;
        regs = '{default: '0};
        pc = 0;
        ledVal = '0;
        stopped = 1'b0;
        stepCount = 0;
        expLeds.delete();
        while (!stopped && stepCount < StepLimit) begin
            ins = prog[pc];
            stepCount++;
            pc = (pc + 1) % `IMEM_DEPTH;
            addr = regs[ins.ra] + wordT'(ins.imm);
            case (ins.opcode)
                opLoadi: regs[ins.rd] = wordT'(ins.imm);
                opLui:   regs[ins.rd] = {ins.imm, 16'h0000};
                opAdd:   regs[ins.rd] = regs[ins.ra] + regs[ins.rb];
                opSub:   regs[ins.rd] = regs[ins.ra] - regs[ins.rb];
                opLoad: begin
                    if (addr[`IO_SELECT_BIT]) begin
                        regs[ins.rd] = wordT'(ledVal);
                    end else begin
                        regs[ins.rd] = ram[addr[DmemBits-1:0]];
                    end
                end
                opStore: begin
                    if (!addr[`IO_SELECT_BIT]) begin
                        ram[addr[DmemBits-1:0]] = regs[ins.rb];
                    end else if (regs[ins.rb][7:0] != ledVal) begin
                        ledVal = regs[ins.rb][7:0];
                        expLeds.push_back(ledVal); // Only a new value is visible.
                    end
                end
                opBeqz: begin
                    if (regs[ins.ra] == '0) begin
                        pc = int'(ins.imm) % `IMEM_DEPTH;
                    end
                end
                opHalt:  stopped = 1'b1;
                default: ;
            endcase
        end
        expFinalLed = ledVal;
        return stopped;
    endfunction

    ////////////////////
    // Stimulus

    task automatic append(instrT word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic resetDut();
        monitorOn = 1'b0;
        @(posedge Clock);
        #1;
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clock);
        #1;
        rstN = 1'b1;
        @(negedge Clock);
    endtask

    task automatic loadProgram();
        @(posedge Clock);
        #1;
        monitorOn = 1'b1;
        for (int i = 0; i < progLen; i++) begin
            loadPort = '{wrStb: 1'b1, addr: 8'(i), data: prog[i]};
            @(posedge Clock);
            #1;
        end
        loadPort = '0;
        loadDone = 1'b1;
        @(posedge Clock);
        #1;
        loadDone = 1'b0;
    endtask

    task automatic runProgram(string name);
        logic expHalted;
        testName = name;
        expHalted = interpret();
        if (expHalted !== 1'b1) begin
            $display("Test %s: the reference program never reaches HALT.", name);
            abortRun();
        end
        cycleLimit = cycleCount + ResetCycles + progLen + `BOOT_HOLD_CYCLES
                     + stepCount * 5 + MarginCycles;
        resetDut();
        checkLed(name, '0, led); // Idle state before loading ends.
        checkHalted(name, 1'b0, halted);
        loadProgram();
        do @(negedge Clock); while (halted !== 1'b1);
        if (expLeds.size() != 0) begin
            $display("Test %s: %0d expected LED changes never appeared.", name, expLeds.size());
            abortRun();
        end
        repeat (3) @(negedge Clock); // Halted must hold until the next reset.
        checkHalted(name, expHalted, halted);
        checkLed(name, expFinalLed, led);
    endtask

    task automatic arithmeticTest();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        a = 16'($random(seed));
        b = 16'($random(seed));
        c = 16'($random(seed));
        progLen = 0;
        append(encode(opLoadi, 0, 0, 0, a));
        append(encode(opLoadi, 1, 0, 0, b));
        append(encode(opLoadi, 3, 0, 0, c));
        append(encode(opAdd, 2, 0, 1, 16'h0));
        append(encode(opSub, 2, 2, 3, 16'h0));
        append(encode(opLui, 3, 0, 0, 16'h8000)); // I/O base address.
        append(encode(opStore, 0, 3, 2, 16'h0));
        append(encode(opHalt, 0, 0, 0, 16'h0));
        runProgram("arithmetic");
    endtask

    task automatic ramRoundTripTest();
        wordT       words [3];
        logic [7:0] addrs [3];
        for (int i = 0; i < 3; i++) begin
            words[i] = $random(seed);
            addrs[i] = 8'(i * 64 + ($random(seed) & 63)); // Distinct RAM slots.
        end
        progLen = 0;
        append(encode(opLoadi, 3, 0, 0, 16'h0));
        for (int i = 0; i < 3; i++) begin
            append(encode(opLui, 0, 0, 0, words[i][31:16]));
            append(encode(opLoadi, 1, 0, 0, words[i][15:0]));
            append(encode(opAdd, 0, 0, 1, 16'h0));
            append(encode(opStore, 0, 3, 0, {8'h00, addrs[i]}));
        end
        append(encode(opLoadi, 2, 0, 0, 16'h0));
        for (int i = 0; i < 3; i++) begin
            append(encode(opLoad, 0, 3, 0, {8'h00, addrs[i]}));
            append(encode(opAdd, 2, 2, 0, 16'h0));
        end
        append(encode(opLui, 3, 0, 0, 16'h8000));
        append(encode(opStore, 0, 3, 2, 16'h0));
        append(encode(opHalt, 0, 0, 0, 16'h0));
        runProgram("ramRoundTrip");
    endtask

    task automatic countdownTest();
        int count;
        count = 3 + ($random(seed) & 3);
        progLen = 0;
        append(encode(opLoadi, 0, 0, 0, 16'(count)));
        append(encode(opLoadi, 1, 0, 0, 16'h1));
        append(encode(opLui, 3, 0, 0, 16'h8000));
        append(encode(opStore, 0, 3, 0, 16'h0)); // Loop head at address 3.
        append(encode(opSub, 0, 0, 1, 16'h0));
        append(encode(opBeqz, 0, 0, 0, 16'd7));
        append(encode(opBeqz, 0, 2, 0, 16'd3)); // r2 stays zero, so this always jumps.
        append(encode(opStore, 0, 3, 0, 16'h0));
        append(encode(opHalt, 0, 0, 0, 16'h0));
        runProgram("countdown");
    endtask

    task automatic ioReadBackTest();
        ledT first;
        first = 8'($random(seed));
        progLen = 0;
        append(encode(opLui, 3, 0, 0, 16'h8000));
        append(encode(opLoadi, 0, 0, 0, {8'h00, first}));
        append(encode(opStore, 0, 3, 0, 16'h0));
        append(encode(opLoad, 1, 3, 0, 16'h0));
        append(encode(opLoadi, 2, 0, 0, 16'h1));
        append(encode(opAdd, 1, 1, 2, 16'h0));
        append(encode(opStore, 0, 3, 1, 16'h0));
        append(encode(opHalt, 0, 0, 0, 16'h0));
        runProgram("ioReadBack");
        checkLed("ioReadBack", first + 8'd1, led);
    endtask

    ////////////////////
    // Main sequence

    initial begin
        rstN = 1'b0;
        loadPort = '0;
        loadDone = 1'b0;
        progLen = 0;
        arithmeticTest();
        ramRoundTripTest();
        countdownTest();
        ioReadBackTest();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
